// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_acc_sequencer
FILELIST  ?= acc_sequencer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== acc_sequencer.f ====
+incdir+verif
logic/acc_seq_pkg.sv
logic/ring_if.sv
logic/context_step.sv
logic/thread_ring.sv
logic/acc_sequencer.sv
verif/tb_acc_sequencer.sv

// ==== logic/acc_seq_pkg.sv ====
package acc_seq_pkg;

    localparam int num_threads_c = 4;
    localparam int phase_w_c     = $clog2(num_threads_c);
    localparam int addr_w_c      = 10;
    localparam int count_w_c     = 6;
    localparam int sel_w_c       = 3;

    // low address bits owned by the sequencer inside each region
    localparam int ob_lsb_c      = 3;
    localparam int wb_lsb_c      = 6;

    localparam int pass_len_c      = 64;
    localparam int pass_fill_c     = 15;
    localparam int writeback_len_c = 8;

    typedef logic [phase_w_c-1:0]     phase_t;
    typedef logic [addr_w_c-1:0]      addr_t;
    typedef logic [count_w_c-1:0]     count_t;
    typedef logic [count_w_c-1:0]     iter_t;
    typedef logic [sel_w_c-1:0]       sel_t;
    typedef logic [num_threads_c-1:0] thread_vec_t;
    typedef iter_t [num_threads_c-1:0] size_vec_t;

    // region bases, indexed by thread
    localparam addr_t ob_base_c [num_threads_c] = '{10'd0, 10'd8, 10'd16, 10'd24};
    localparam addr_t wb_base_c [num_threads_c] = '{10'd0, 10'd64, 10'd128, 10'd192};

    typedef enum logic [2:0] {
        IDLE,
        START,
        CLEAR,
        MAC,
        UPDATE,
        WRITE_BACK,
        DONE
    } state_e;

    typedef struct packed {
        state_e state;
        iter_t  iter;
        count_t count;
        addr_t  ib_addr;
        addr_t  ob_addr;
        addr_t  wb_w_addr;
        addr_t  wb_r_addr;
        logic   ob_wr;
        logic   wb_wr;
        logic   acc_sel;
        logic   acc_upd;
        logic   acc_clr;
        sel_t   ml_sel;
        phase_t thread;
    } ctx_t;

endpackage

// ==== logic/acc_sequencer.sv ====
module acc_sequencer (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  acc_seq_pkg::thread_vec_t start_i,
    input  acc_seq_pkg::size_vec_t   size_i,
    output acc_seq_pkg::thread_vec_t valid_o,
    output acc_seq_pkg::addr_t       ib_r_addr_o,
    output acc_seq_pkg::phase_t      ib_sel_o,
    output acc_seq_pkg::addr_t       wb_w_addr_o,
    output acc_seq_pkg::addr_t       wb_r_addr_o,
    output logic                     wb_wr_o,
    output logic                     acc_sel_o,
    output logic                     acc_upd_o,
    output logic                     acc_clr_o,
    output acc_seq_pkg::addr_t       ob_addr_o,
    output logic                     ob_wr_o,
    output acc_seq_pkg::sel_t        ml_sel_o
);

    ring_if ring (
        .clk_i  (clk_i),
        .rst_ni (rst_ni)
    );

    // context storage and output taps
    thread_ring u_thread_ring (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ring        (ring.ring_mp),
        .valid_o     (valid_o),
        .ib_r_addr_o (ib_r_addr_o),
        .ib_sel_o    (ib_sel_o),
        .wb_w_addr_o (wb_w_addr_o),
        .wb_r_addr_o (wb_r_addr_o),
        .wb_wr_o     (wb_wr_o),
        .acc_sel_o   (acc_sel_o),
        .acc_upd_o   (acc_upd_o),
        .acc_clr_o   (acc_clr_o),
        .ob_addr_o   (ob_addr_o),
        .ob_wr_o     (ob_wr_o),
        .ml_sel_o    (ml_sel_o)
    );

    // per-thread FSM step at the ring tail
    context_step u_context_step (
        .start_i (start_i),
        .size_i  (size_i),
        .ring    (ring.step_mp)
    );

endmodule

// ==== logic/context_step.sv ====
module context_step (
    input  acc_seq_pkg::thread_vec_t start_i,
    input  acc_seq_pkg::size_vec_t   size_i,
    ring_if.step_mp                  ring
);

    acc_seq_pkg::ctx_t  tail;
    acc_seq_pkg::ctx_t  head_d;
    logic               start;
    logic               valid_now;
    acc_seq_pkg::iter_t size;
    logic               pass_end;
    logic               in_fill;
    logic               wb_last;
    logic               valid_set_d;
    logic               valid_clr_d;

    // next weight address, wrapping inside the thread's region
    function automatic acc_seq_pkg::addr_t wb_next(acc_seq_pkg::addr_t a);
        acc_seq_pkg::addr_t n;
        n = a;
        n[acc_seq_pkg::wb_lsb_c-1:0] = a[acc_seq_pkg::wb_lsb_c-1:0] + 1'b1;
        return n;
    endfunction

    assign tail      = ring.tail;
    assign start     = start_i[ring.phase];
    assign size      = size_i[ring.phase];
    assign valid_now = ring.valid_q[ring.phase];

    assign pass_end = tail.count == acc_seq_pkg::count_t'(acc_seq_pkg::pass_len_c - 1);
    assign in_fill  = tail.count < acc_seq_pkg::count_t'(acc_seq_pkg::pass_fill_c);
    assign wb_last  = tail.count == acc_seq_pkg::count_t'(acc_seq_pkg::writeback_len_c - 1);

    always_comb begin
        head_d         = tail;
        head_d.ob_wr   = 1'b0;
        head_d.wb_wr   = 1'b0;
        head_d.acc_sel = 1'b0;
        head_d.acc_upd = 1'b0;
        head_d.acc_clr = 1'b0;
        valid_set_d    = 1'b0;
        valid_clr_d    = 1'b0;

        case (tail.state)
            acc_seq_pkg::IDLE: begin
                head_d.iter    = size;
                head_d.count   = '0;
                head_d.ib_addr = '0;
                head_d.ob_addr[acc_seq_pkg::ob_lsb_c-1:0]   = '0;
                head_d.wb_w_addr[acc_seq_pkg::wb_lsb_c-1:0] = '0;
                head_d.wb_r_addr[acc_seq_pkg::wb_lsb_c-1:0] = '0;
                head_d.ml_sel  = '0;
                head_d.thread  = ring.phase;
                valid_clr_d    = valid_now;
                if (start) begin
                    head_d.state = acc_seq_pkg::START;
                end
            end

            acc_seq_pkg::START: begin
                // read pointer sits one behind so CLEAR lands on offset 0
                head_d.wb_r_addr[acc_seq_pkg::wb_lsb_c-1:0] = '1;
                head_d.wb_w_addr[acc_seq_pkg::wb_lsb_c-1:0] = '0;
                head_d.wb_wr   = 1'b1;
                head_d.acc_clr = 1'b1;
                head_d.state   = acc_seq_pkg::CLEAR;
            end

            acc_seq_pkg::CLEAR: begin
                head_d.ib_addr   = tail.ib_addr + acc_seq_pkg::addr_t'(1);
                head_d.wb_w_addr = wb_next(tail.wb_w_addr);
                head_d.wb_r_addr = wb_next(tail.wb_r_addr);
                head_d.count     = tail.count + acc_seq_pkg::count_t'(1);
                head_d.wb_wr     = 1'b1;
                head_d.acc_clr   = 1'b1;
                head_d.state     = acc_seq_pkg::MAC;
            end

            acc_seq_pkg::MAC: begin
                head_d.wb_w_addr = wb_next(tail.wb_w_addr);
                head_d.wb_r_addr = wb_next(tail.wb_r_addr);
                head_d.count     = tail.count + acc_seq_pkg::count_t'(1);
                head_d.wb_wr     = 1'b1;
                if (in_fill || pass_end) begin
                    head_d.ib_addr = tail.ib_addr + acc_seq_pkg::addr_t'(1);
                end else begin
                    // inputs already loaded, reuse them from the accumulator side
                    head_d.acc_sel = 1'b1;
                end
                if (pass_end) begin
                    if (tail.iter == '0) begin
                        head_d.state = acc_seq_pkg::WRITE_BACK;
                    end else begin
                        head_d.state = acc_seq_pkg::UPDATE;
                    end
                end
            end

            acc_seq_pkg::UPDATE: begin
                head_d.iter      = tail.iter - acc_seq_pkg::iter_t'(1);
                head_d.ib_addr   = tail.ib_addr + acc_seq_pkg::addr_t'(1);
                head_d.wb_w_addr = wb_next(tail.wb_w_addr);
                head_d.wb_r_addr = wb_next(tail.wb_r_addr);
                head_d.count     = tail.count + acc_seq_pkg::count_t'(1);
                head_d.wb_wr     = 1'b1;
                head_d.acc_upd   = 1'b1;
                head_d.state     = acc_seq_pkg::MAC;
            end

            acc_seq_pkg::WRITE_BACK: begin
                head_d.ob_wr   = 1'b1;
                head_d.ob_addr[acc_seq_pkg::ob_lsb_c-1:0] =
                    tail.count[acc_seq_pkg::ob_lsb_c-1:0];
                head_d.ml_sel  = acc_seq_pkg::sel_t'(tail.count);
                head_d.acc_upd = tail.count == '0;
                head_d.count   = tail.count + acc_seq_pkg::count_t'(1);
                if (wb_last) begin
                    head_d.state = acc_seq_pkg::DONE;
                end
            end

            acc_seq_pkg::DONE: begin
                valid_set_d = !valid_now;
                if (!start) begin
                    head_d.state = acc_seq_pkg::IDLE;
                end
            end

            default: begin
                head_d.state = acc_seq_pkg::IDLE;
            end
        endcase
    end

    assign ring.head      = head_d;
    assign ring.valid_set = valid_set_d;
    assign ring.valid_clr = valid_clr_d;

    // output writes come only out of the write-back phase
    ob_wr_only_in_wb: assert property (
        @(posedge ring.clk_i) disable iff (!ring.rst_ni)
        ring.head.ob_wr |-> ring.tail.state == acc_seq_pkg::WRITE_BACK
    );

endmodule

// ==== logic/ring_if.sv ====
interface ring_if (
    input logic clk_i,
    input logic rst_ni
);
    acc_seq_pkg::ctx_t        tail;
    acc_seq_pkg::phase_t      phase;
    acc_seq_pkg::ctx_t        head;
    logic                     valid_set;
    logic                     valid_clr;
    acc_seq_pkg::thread_vec_t valid_q;

    modport ring_mp (
        output tail,
        output phase,
        output valid_q,
        input  head,
        input  valid_set,
        input  valid_clr
    );

    modport step_mp (
        input  clk_i,
        input  rst_ni,
        input  tail,
        input  phase,
        input  valid_q,
        output head,
        output valid_set,
        output valid_clr
    );
endinterface

// ==== logic/thread_ring.sv ====
module thread_ring (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    ring_if.ring_mp                  ring,
    output acc_seq_pkg::thread_vec_t valid_o,
    output acc_seq_pkg::addr_t       ib_r_addr_o,
    output acc_seq_pkg::phase_t      ib_sel_o,
    output acc_seq_pkg::addr_t       wb_w_addr_o,
    output acc_seq_pkg::addr_t       wb_r_addr_o,
    output logic                     wb_wr_o,
    output logic                     acc_sel_o,
    output logic                     acc_upd_o,
    output logic                     acc_clr_o,
    output acc_seq_pkg::addr_t       ob_addr_o,
    output logic                     ob_wr_o,
    output acc_seq_pkg::sel_t        ml_sel_o
);

    localparam int last_c = acc_seq_pkg::num_threads_c - 1;

    acc_seq_pkg::phase_t      phase_q;
    acc_seq_pkg::ctx_t        stage_q [acc_seq_pkg::num_threads_c];
    acc_seq_pkg::thread_vec_t valid_q;

    // idle context of one thread, parked at its own region bases
    function automatic acc_seq_pkg::ctx_t reset_ctx(int t);
        acc_seq_pkg::ctx_t c;
        c           = '0;
        c.state     = acc_seq_pkg::IDLE;
        c.ob_addr   = acc_seq_pkg::ob_base_c[t];
        c.wb_w_addr = acc_seq_pkg::wb_base_c[t];
        c.wb_r_addr = acc_seq_pkg::wb_base_c[t];
        c.thread    = acc_seq_pkg::phase_t'(t);
        return c;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // stage t holds thread t, matching the phase at each tail visit
            phase_q <= acc_seq_pkg::phase_t'(last_c);
            for (int i = 0; i < acc_seq_pkg::num_threads_c; i++) begin
                stage_q[i] <= reset_ctx(i);
            end
        end else begin
            phase_q    <= phase_q - 1'b1;
            stage_q[0] <= ring.head;
            for (int i = 1; i < acc_seq_pkg::num_threads_c; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (ring.valid_set) begin
            valid_q[phase_q] <= 1'b1;
        end else if (ring.valid_clr) begin
            valid_q[phase_q] <= 1'b0;
        end
    end

    assign ring.tail    = stage_q[last_c];
    assign ring.phase   = phase_q;
    assign ring.valid_q = valid_q;

    // taps line up with the buffer read latencies downstream
    assign ib_r_addr_o = stage_q[0].ib_addr;
    assign ib_sel_o    = stage_q[1].thread;
    assign wb_w_addr_o = stage_q[1].wb_w_addr;
    assign wb_r_addr_o = stage_q[1].wb_r_addr;
    assign wb_wr_o     = stage_q[1].wb_wr;
    assign acc_sel_o   = stage_q[1].acc_sel;
    assign acc_upd_o   = stage_q[1].acc_upd;
    assign acc_clr_o   = stage_q[1].acc_clr;
    assign ob_addr_o   = stage_q[2].ob_addr;
    assign ob_wr_o     = stage_q[2].ob_wr;
    assign ml_sel_o    = stage_q[2].ml_sel;
    assign valid_o     = valid_q;

    valid_strobes_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(ring.valid_set && ring.valid_clr)
    );

endmodule

// ==== verif/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// right-shifting galois register, taps 32'h80200003
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

// cycles from start to valid, four cycles per step
function automatic int latency_bound(input acc_seq_pkg::iter_t size);
    return 4 * (76 + 64 * int'(size));
endfunction

task automatic check_vec(input string name, input acc_seq_pkg::thread_vec_t exp,
                         input acc_seq_pkg::thread_vec_t act);
    if (act !== exp) begin
        stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_addr(input string name, input acc_seq_pkg::addr_t exp,
                          input acc_seq_pkg::addr_t act);
    if (act !== exp) begin
        stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_sel(input string name, input acc_seq_pkg::sel_t exp,
                         input acc_seq_pkg::sel_t act);
    if (act !== exp) begin
        stop_on_error($sformatf("mismatch in %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        stop_on_error($sformatf("mismatch in %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

// each masked thread gets its own bound from its size
task automatic wait_valid_rise(input acc_seq_pkg::thread_vec_t mask,
                               input acc_seq_pkg::size_vec_t sizes, input string name);
    acc_seq_pkg::thread_vec_t seen;
    int cycles;
    seen   = '0;
    cycles = 0;
    while ((seen & mask) != mask) begin
        sample_cycle();
        cycles++;
        check_vec($sformatf("%s foreign valid", name), '0, valid_o & ~mask);
        for (int t = 0; t < acc_seq_pkg::num_threads_c; t++) begin
            if (mask[t] && !seen[t]) begin
                if (valid_o[t]) begin
                    seen[t] = 1'b1;
                end else if (cycles > latency_bound(sizes[t])) begin
                    stop_on_error($sformatf("%s: thread %0d valid did not rise in %0d cycles",
                                            name, t, cycles));
                end
            end
        end
    end
endtask

task automatic wait_valid_fall(input int t, input int limit, input string name);
    int cycles;
    cycles = 0;
    sample_cycle();
    while (valid_o[t]) begin
        if (cycles >= limit) begin
            stop_on_error($sformatf("%s: thread %0d valid still high after %0d cycles",
                                    name, t, cycles));
        end else begin
            sample_cycle();
            cycles++;
        end
    end
endtask

`endif

// ==== verif/tb_acc_sequencer.sv ====
module tb_acc_sequencer;

    localparam int nt_c = acc_seq_pkg::num_threads_c;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    acc_seq_pkg::thread_vec_t start_i;
    acc_seq_pkg::size_vec_t   size_i;
    acc_seq_pkg::thread_vec_t valid_o;
    acc_seq_pkg::addr_t       ib_r_addr_o;
    acc_seq_pkg::phase_t      ib_sel_o;
    acc_seq_pkg::addr_t       wb_w_addr_o;
    acc_seq_pkg::addr_t       wb_r_addr_o;
    logic                     wb_wr_o;
    logic                     acc_sel_o;
    logic                     acc_upd_o;
    logic                     acc_clr_o;
    acc_seq_pkg::addr_t       ob_addr_o;
    logic                     ob_wr_o;
    acc_seq_pkg::sel_t        ml_sel_o;

    logic [31:0]        lfsr_q;
    int                 ob_cnt [nt_c];
    int                 wb_cnt [nt_c];
    int                 upd_cnt [nt_c];
    int                 clr_cnt [nt_c];
    int                 sel_cnt [nt_c];
    int                 max_ib;
    acc_seq_pkg::addr_t ob_log [nt_c][8];
    acc_seq_pkg::sel_t  sel_log [nt_c][8];

    `include "tb_checks.svh"

    always #4 clk_i = ~clk_i;

    acc_sequencer dut (
        .clk_i, .rst_ni, .start_i, .size_i, .valid_o, .ib_r_addr_o, .ib_sel_o,
        .wb_w_addr_o, .wb_r_addr_o, .wb_wr_o, .acc_sel_o, .acc_upd_o, .acc_clr_o,
        .ob_addr_o, .ob_wr_o, .ml_sel_o
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic clear_counts();
        for (int t = 0; t < nt_c; t++) begin
            ob_cnt[t]  = 0;
            wb_cnt[t]  = 0;
            upd_cnt[t] = 0;
            clr_cnt[t] = 0;
            sel_cnt[t] = 0;
        end
        max_ib = 0;
    endtask

    // outputs are registered, so the falling edge sees settled values
    task automatic sample_cycle();
        int                 t;
        acc_seq_pkg::addr_t exp_r;
        @(negedge clk_i);
        if (int'(ib_r_addr_o) > max_ib) begin
            max_ib = int'(ib_r_addr_o);
        end
        if (acc_upd_o) begin
            upd_cnt[int'(ib_sel_o)]++;
        end
        if (acc_clr_o) begin
            clr_cnt[int'(ib_sel_o)]++;
        end
        if (acc_sel_o) begin
            sel_cnt[int'(ib_sel_o)]++;
        end
        if (wb_wr_o) begin
            // read pointer trails the write pointer by one inside the same region
            exp_r      = wb_w_addr_o;
            exp_r[5:0] = wb_w_addr_o[5:0] - 6'd1;
            check_addr("weight read addr", exp_r, wb_r_addr_o);
            t = int'(wb_w_addr_o >> 6);
            if (t >= nt_c) begin
                stop_on_error($sformatf("weight write at %h is outside every region", wb_w_addr_o));
            end else begin
                wb_cnt[t]++;
            end
        end
        if (ob_wr_o) begin
            t = int'(ob_addr_o >> 3);
            if (t >= nt_c) begin
                stop_on_error($sformatf("output write at %h is outside every region", ob_addr_o));
            end else begin
                if (ob_cnt[t] < 8) begin
                    ob_log[t][ob_cnt[t]]  = ob_addr_o;
                    sel_log[t][ob_cnt[t]] = ml_sel_o;
                end
                ob_cnt[t]++;
            end
        end
    endtask

    task automatic draw_two_bits(output logic [1:0] v);
        for (int i = 0; i < 2; i++) begin
            v[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic drive_inputs(input acc_seq_pkg::thread_vec_t s,
                                input acc_seq_pkg::size_vec_t z);
        @(posedge clk_i);
        #1;
        start_i = s;
        size_i  = z;
    endtask

    // results land at base + 0..7 with matching select
    task automatic check_write_back(input int t, input string name);
        check_count($sformatf("%s t%0d ob_wr count", name, t), 8, ob_cnt[t]);
        for (int k = 0; k < 8; k++) begin
            check_addr($sformatf("%s t%0d ob_addr %0d", name, t, k),
                       acc_seq_pkg::addr_t'(8 * t + k), ob_log[t][k]);
            check_sel($sformatf("%s t%0d ml_sel %0d", name, t, k),
                      acc_seq_pkg::sel_t'(k), sel_log[t][k]);
        end
    endtask

    task automatic test_reset_state();
        clear_counts();
        for (int i = 0; i < 20; i++) begin
            sample_cycle();
            check_vec("reset valid", '0, valid_o);
            check_count("reset strobes", 0,
                        int'(wb_wr_o) + int'(ob_wr_o) + int'(acc_upd_o) + int'(acc_clr_o));
        end
    endtask

    task automatic test_single_write_back(output int t, output acc_seq_pkg::iter_t sz);
        logic [1:0]               bits;
        acc_seq_pkg::size_vec_t   z;
        acc_seq_pkg::thread_vec_t mask;
        draw_two_bits(bits);
        t = int'(bits);
        draw_two_bits(bits);
        sz   = acc_seq_pkg::iter_t'(bits);
        z    = '0;
        z[t] = sz;
        mask = acc_seq_pkg::thread_vec_t'(1 << t);
        clear_counts();
        drive_inputs(mask, z);
        wait_valid_rise(mask, z, "single");
        check_vec("single valid", mask, valid_o);
        check_write_back(t, "single");
    endtask

    task automatic test_pass_accounting(input int t, input acc_seq_pkg::iter_t sz);
        check_count("pass wb_wr", 65 + 64 * int'(sz), wb_cnt[t]);
        check_count("pass acc_upd", int'(sz) + 1, upd_cnt[t]);
        check_count("pass acc_clr", 2, clr_cnt[t]);
        // mac counts 15 to 62 of every pass reuse loaded inputs
        check_count("pass acc_sel", 48 * (int'(sz) + 1), sel_cnt[t]);
        check_count("pass max ib addr", 16 * (int'(sz) + 1), max_ib);
        for (int o = 0; o < nt_c; o++) begin
            if (o != t) begin
                check_count($sformatf("pass foreign wb_wr t%0d", o), 0, wb_cnt[o]);
            end
        end
    endtask

    task automatic test_release(input int t);
        drive_inputs('0, size_i);
        wait_valid_fall(t, 48, "release");
        clear_counts();
        repeat (64) sample_cycle();
        check_vec("release valid", '0, valid_o);
        check_count("release strobes", 0,
                    wb_cnt[t] + ob_cnt[t] + upd_cnt[t] + clr_cnt[t] + sel_cnt[t]);
    endtask

    task automatic test_concurrent();
        logic [1:0]             bits;
        acc_seq_pkg::size_vec_t z;
        for (int t = 0; t < nt_c; t++) begin
            draw_two_bits(bits);
            z[t] = acc_seq_pkg::iter_t'(bits);
        end
        clear_counts();
        drive_inputs('1, z);
        wait_valid_rise('1, z, "concurrent");
        for (int t = 0; t < nt_c; t++) begin
            check_write_back(t, "concurrent");
            check_count($sformatf("concurrent t%0d wb_wr", t), 65 + 64 * int'(z[t]), wb_cnt[t]);
        end
        drive_inputs('0, z);
        for (int t = 0; t < nt_c; t++) begin
            wait_valid_fall(t, 48, "concurrent release");
        end
    endtask

    initial begin
        int                 thread_idx;
        acc_seq_pkg::iter_t size_val;
        rst_ni  = 1'b0;
        start_i = '0;
        size_i  = '0;
        lfsr_q  = 32'hf578132b;
        clear_counts();
        repeat (5) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        test_reset_state();
        test_single_write_back(thread_idx, size_val);
        test_pass_accounting(thread_idx, size_val);
        test_release(thread_idx);
        test_concurrent();
        $display("Test passed");
        $finish;
    end

endmodule
